//--- compile.f
+incdir+logic
logic/soc_evt_pkg.sv
logic/evt_collector.sv
logic/evt_fifo.sv
logic/cluster_evt_tx.sv
logic/soc_evt_bridge.sv
sim/soc_evt_bridge_tb.sv

//--- logic/cluster_evt_tx.sv
`timescale 1ns/1ps
`include "soc_evt_params.svh"

module cluster_evt_tx (
  input  logic                   s_soc_clk,
  input  logic                   s_soc_rstn,
  input  soc_evt_pkg::cl_event_t evt_i,
  input  logic                   evt_valid_i,
  output logic                   evt_ready_o,
  output soc_evt_pkg::cl_event_t cl_evt_data_o,
  output logic                   cl_evt_req_o,
  input  logic                   cl_evt_ack_i
);
  import soc_evt_pkg::*;

  logic [`EVT_SYNC_STAGES-1:0] ack_sync_q;
  logic                        busy;
  logic                        send;

  // ********************
  // two-phase link
  // ********************

  // a request is open until the synchronized ack matches it
  assign busy        = ack_sync_q[`EVT_SYNC_STAGES-1] ^ cl_evt_req_o;
  assign evt_ready_o = ~busy;
  assign send        = evt_valid_i & ~busy;

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      ack_sync_q    <= '0;
      cl_evt_req_o  <= 1'b0;
      cl_evt_data_o <= cl_event_t'('0);
    end else begin
      ack_sync_q[0] <= cl_evt_ack_i;
      for (int s = 1; s < `EVT_SYNC_STAGES; s++) begin
        ack_sync_q[s] <= ack_sync_q[s-1];
      end
      if (send) begin
        // data and request flip on the same edge
        cl_evt_data_o <= evt_i;
        cl_evt_req_o  <= ~cl_evt_req_o;
      end
    end
  end

  // held until the cluster answers, synchronizer delay included
  assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    (cl_evt_req_o != cl_evt_ack_i) |=> $stable(cl_evt_data_o))
    else $error("cluster_evt_tx: data changed while request open");

endmodule

//--- logic/evt_collector.sv
`timescale 1ns/1ps
`include "soc_evt_params.svh"

module evt_collector (
  input  logic                     s_soc_clk,
  input  logic                     s_soc_rstn,
  input  logic [`N_CL_EVT_SRC-1:0] cl_evt_toggle_i,
  output logic [`N_CL_EVT_SRC-1:0] cl_evt_ack_o,
  output soc_evt_pkg::cl_event_t   evt_o,
  output logic                     evt_valid_o,
  input  logic                     evt_ready_i
);
  import soc_evt_pkg::*;

  logic [`EVT_SYNC_STAGES-1:0][`N_CL_EVT_SRC-1:0] sync_q;
  logic [`N_CL_EVT_SRC-1:0]                       seen_q;
  logic [`N_CL_EVT_SRC-1:0]                       pending_q;
  logic [`N_CL_EVT_SRC-1:0]                       flip;
  logic [`N_CL_EVT_SRC-1:0]                       take;
  logic [`N_CL_EVT_SRC-1:0][`EVT_SEQ_WIDTH-1:0]   seq_q;
  logic [EVT_SRC_WIDTH-1:0]                       pick;
  logic [EVT_SRC_WIDTH-1:0]                       cur_src;
  logic [EVT_SRC_WIDTH-1:0]                       held_src_q;
  logic                                           hold_q;
  logic                                           accept;

  // ********************
  // toggle detection
  // ********************

  // any change against the last seen level is one event
  assign flip = sync_q[`EVT_SYNC_STAGES-1] ^ seen_q;

  // lowest pending source wins
  always_comb begin
    pick = '0;
    for (int i = `N_CL_EVT_SRC - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        pick = EVT_SRC_WIDTH'(i);
      end
    end
  end

  // keep the offered source while the fifo stalls us
  assign cur_src     = hold_q ? held_src_q : pick;
  assign evt_valid_o = |pending_q;
  assign evt_o.src   = evt_src_e'(cur_src);
  assign evt_o.seq   = seq_q[cur_src];
  assign accept      = evt_valid_o & evt_ready_i;

  always_comb begin
    take = '0;
    if (accept) begin
      take[cur_src] = 1'b1;
    end
  end

  // ********************
  // state
  // ********************

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      sync_q       <= '0;
      seen_q       <= '0;
      pending_q    <= '0;
      seq_q        <= '0;
      cl_evt_ack_o <= '0;
      hold_q       <= 1'b0;
      held_src_q   <= '0;
    end else begin
      sync_q[0] <= cl_evt_toggle_i;
      for (int s = 1; s < `EVT_SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
      seen_q       <= sync_q[`EVT_SYNC_STAGES-1];
      pending_q    <= (pending_q & ~take) | flip;
      // ack follows only once the word sits in the fifo
      cl_evt_ack_o <= cl_evt_ack_o ^ take;
      hold_q       <= evt_valid_o & ~evt_ready_i;
      held_src_q   <= cur_src;
      if (accept) begin
        seq_q[cur_src] <= seq_q[cur_src] + 1'b1;
      end
    end
  end

  // offered word may not change until the fifo takes it
  assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    evt_valid_o && !evt_ready_i |=> evt_valid_o && $stable(evt_o))
    else $error("evt_collector: event word changed while stalled");

endmodule

//--- logic/evt_fifo.sv
`timescale 1ns/1ps
`include "soc_evt_params.svh"

module evt_fifo #(
  parameter type         payload_t = soc_evt_pkg::cl_event_t,
  parameter int unsigned DEPTH     = `EVT_FIFO_DEPTH
) (
  input  logic     s_soc_clk,
  input  logic     s_soc_rstn,
  input  payload_t push_data_i,
  input  logic     push_valid_i,
  output logic     push_ready_o,
  output payload_t pop_data_o,
  output logic     pop_valid_o,
  input  logic     pop_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t             mem [DEPTH];
  logic     [PTR_W-1:0] wr_ptr_q;
  logic     [PTR_W-1:0] rd_ptr_q;
  logic     [CNT_W-1:0] count_q;
  logic                 push;
  logic                 pop;

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem[rd_ptr_q];
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  // ********************
  // storage
  // ********************

  always_ff @(posedge s_soc_clk) begin
    if (push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  // ********************
  // pointers and count
  // ********************

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    count_q <= CNT_W'(DEPTH))
    else $error("evt_fifo: occupancy above depth");

  // read side only moves when there was something to read
  assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    !$stable(rd_ptr_q) |-> $past(count_q) != '0)
    else $error("evt_fifo: pop from empty fifo");

endmodule

//--- logic/soc_evt_bridge.sv
`timescale 1ns/1ps
`include "soc_evt_params.svh"

module soc_evt_bridge (
  input  logic                     s_soc_clk,
  input  logic                     s_soc_rstn,
  input  logic [`N_CL_EVT_SRC-1:0] cl_evt_toggle_i,
  output logic [`N_CL_EVT_SRC-1:0] cl_evt_ack_o,
  output soc_evt_pkg::cl_event_t   cl_evt_data_o,
  output logic                     cl_evt_req_o,
  input  logic                     cl_evt_ack_i
);
  import soc_evt_pkg::*;

  cl_event_t col_evt;
  logic      col_valid;
  logic      col_ready;
  cl_event_t tx_evt;
  logic      tx_valid;
  logic      tx_ready;

  // ********************
  // cluster toggles in
  // ********************

  evt_collector u_collector (
    .s_soc_clk      (s_soc_clk),
    .s_soc_rstn     (s_soc_rstn),
    .cl_evt_toggle_i(cl_evt_toggle_i),
    .cl_evt_ack_o   (cl_evt_ack_o),
    .evt_o          (col_evt),
    .evt_valid_o    (col_valid),
    .evt_ready_i    (col_ready)
  );

  evt_fifo #(
    .payload_t(cl_event_t),
    .DEPTH    (`EVT_FIFO_DEPTH)
  ) u_fifo (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_soc_rstn),
    .push_data_i (col_evt),
    .push_valid_i(col_valid),
    .push_ready_o(col_ready),
    .pop_data_o  (tx_evt),
    .pop_valid_o (tx_valid),
    .pop_ready_i (tx_ready)
  );

  // event words out to the cluster
  cluster_evt_tx u_tx (
    .s_soc_clk    (s_soc_clk),
    .s_soc_rstn   (s_soc_rstn),
    .evt_i        (tx_evt),
    .evt_valid_i  (tx_valid),
    .evt_ready_o  (tx_ready),
    .cl_evt_data_o(cl_evt_data_o),
    .cl_evt_req_o (cl_evt_req_o),
    .cl_evt_ack_i (cl_evt_ack_i)
  );

endmodule

//--- logic/soc_evt_params.svh
`ifndef SOC_EVT_PARAMS_SVH
`define SOC_EVT_PARAMS_SVH

// cluster event sources: dma event, dma irq, prefetch event
`define N_CL_EVT_SRC 3

// event word toward the cluster
`define EVNT_WIDTH 8

// per-source sequence count, wraps at 64
`define EVT_SEQ_WIDTH 6

// ********************
// buffering and crossing
// ********************

`define EVT_FIFO_DEPTH 4
`define EVT_SYNC_STAGES 2

`endif

//--- logic/soc_evt_pkg.sv
`include "soc_evt_params.svh"

package soc_evt_pkg;

  // source tag takes whatever the sequence count leaves of the word
  localparam int unsigned EVT_SRC_WIDTH = `EVNT_WIDTH - `EVT_SEQ_WIDTH;

  // ********************
  // event sources
  // ********************

  typedef enum logic [EVT_SRC_WIDTH-1:0] {
    EVT_SRC_DMA_EVT = EVT_SRC_WIDTH'(0),
    EVT_SRC_DMA_IRQ = EVT_SRC_WIDTH'(1),
    EVT_SRC_PF_EVT  = EVT_SRC_WIDTH'(2)
  } evt_src_e;

  // ********************
  // event word
  // ********************

  // src sits in the upper bits
  typedef struct packed {
    evt_src_e                  src;
    logic [`EVT_SEQ_WIDTH-1:0] seq;
  } cl_event_t;

endpackage

//--- sim/soc_evt_bridge_tb.sv
`timescale 1ns/1ps
`include "soc_evt_params.svh"

module soc_evt_bridge_tb;

  typedef struct packed {
    logic [`N_CL_EVT_SRC-1:0] mask;
    logic [7:0]               delay;
    logic [7:0]               reps;
  } stim_row_t;

  localparam int N_ROWS = 6;

  logic                      s_soc_clk;
  logic                      s_soc_rstn;
  logic [`N_CL_EVT_SRC-1:0]  cl_evt_toggle_i;
  logic [`N_CL_EVT_SRC-1:0]  cl_evt_ack_o;
  soc_evt_pkg::cl_event_t    cl_evt_data_o;
  logic                      cl_evt_req_o;
  logic                      cl_evt_ack_i;

  stim_row_t                 stim_rows [N_ROWS];
  string                     row_names [N_ROWS];
  logic [`EVNT_WIDTH-1:0]    expected_q [$];
  logic [`EVNT_WIDTH-1:0]    received_q [$];
  logic [`EVT_SEQ_WIDTH-1:0] model_seq [`N_CL_EVT_SRC];
  logic [`N_CL_EVT_SRC-1:0]  prev_ack;
  int unsigned               cur_delay;
  int unsigned               wait_cnt;
  logic                      pending;
  int unsigned               cycles = 0;
  int unsigned               cycle_limit;
  int                        errors;
  int                        tests_run;
  int                        tests_failed;

  soc_evt_bridge u_dut (
    .s_soc_clk      (s_soc_clk),
    .s_soc_rstn     (s_soc_rstn),
    .cl_evt_toggle_i(cl_evt_toggle_i),
    .cl_evt_ack_o   (cl_evt_ack_o),
    .cl_evt_data_o  (cl_evt_data_o),
    .cl_evt_req_o   (cl_evt_req_o),
    .cl_evt_ack_i   (cl_evt_ack_i)
  );

  initial s_soc_clk = 1'b0;
  always #20 s_soc_clk = ~s_soc_clk;

  always @(posedge s_soc_clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("run stalled: events still outstanding after %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ********************
  // cluster model
  // ********************

  // take the word on a request flip, answer after the row's delay
  always @(negedge s_soc_clk) begin
    if (s_soc_rstn) begin
      if (!pending && (cl_evt_req_o != cl_evt_ack_i)) begin
        received_q.push_back(cl_evt_data_o);
        pending  = 1'b1;
        wait_cnt = cur_delay;
      end else if (pending) begin
        if (wait_cnt == 0) begin
          cl_evt_ack_i <= cl_evt_req_o;
          pending = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  // an ack bit may only move to meet a toggle the cluster already flipped
  always @(negedge s_soc_clk) begin
    if (s_soc_rstn) begin
      for (int s = 0; s < `N_CL_EVT_SRC; s++) begin
        if ((cl_evt_ack_o[s] != prev_ack[s]) && (cl_evt_ack_o[s] != cl_evt_toggle_i[s])) begin
          $display("ack bit %0d flipped at %0t ns without a new toggle", s, $time);
          errors++;
        end
      end
    end
    prev_ack = cl_evt_ack_o;
  end

  // ********************
  // helpers
  // ********************

  task automatic load_rows();
    stim_rows[0] = '{mask: 3'b001, delay: 8'd2,  reps: 8'd1};
    stim_rows[1] = '{mask: 3'b010, delay: 8'd2,  reps: 8'd1};
    stim_rows[2] = '{mask: 3'b100, delay: 8'd2,  reps: 8'd1};
    stim_rows[3] = '{mask: 3'b111, delay: 8'd1,  reps: 8'd1};
    stim_rows[4] = '{mask: 3'b111, delay: 8'd20, reps: 8'd4};
    stim_rows[5] = '{mask: 3'b001, delay: 8'd0,  reps: 8'd70};
    row_names[0] = "single dma event";
    row_names[1] = "single dma irq";
    row_names[2] = "single prefetch event";
    row_names[3] = "all sources at once";
    row_names[4] = "slow cluster ack";
    row_names[5] = "sequence wrap";
  endtask

  function automatic int unsigned stall_limit();
    int unsigned total;
    int unsigned max_delay;
    total     = 0;
    max_delay = 0;
    for (int r = 0; r < N_ROWS; r++) begin
      total += stim_rows[r].reps;
      if (stim_rows[r].delay > max_delay) begin
        max_delay = stim_rows[r].delay;
      end
    end
    return total * (3 * (max_delay + 10)) + 200;
  endfunction

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s expected %02h got %02h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic raise_events(input logic [`N_CL_EVT_SRC-1:0] mask);
    logic [`N_CL_EVT_SRC-1:0] flip;
    @(negedge s_soc_clk);
    // sources with an event still outstanding stay put
    flip = mask & ~(cl_evt_toggle_i ^ cl_evt_ack_o);
    for (int s = 0; s < `N_CL_EVT_SRC; s++) begin
      if (flip[s]) begin
        expected_q.push_back({soc_evt_pkg::EVT_SRC_WIDTH'(s), model_seq[s]});
        model_seq[s] = model_seq[s] + 1'b1;
      end
    end
    cl_evt_toggle_i <= cl_evt_toggle_i ^ flip;
    @(negedge s_soc_clk);
    while (!((cl_evt_ack_o == cl_evt_toggle_i) && (received_q.size() >= expected_q.size()))) begin
      @(negedge s_soc_clk);
    end
  endtask

  task automatic compare_words();
    logic [`EVNT_WIDTH-1:0] exp_w;
    logic [`EVNT_WIDTH-1:0] got_w;
    while ((expected_q.size() > 0) && (received_q.size() > 0)) begin
      exp_w = expected_q.pop_front();
      got_w = received_q.pop_front();
      check_value("cl_evt_data_o", exp_w, got_w);
    end
    if (received_q.size() > 0) begin
      $display("%0d event words arrived that no toggle raised", received_q.size());
      errors++;
      received_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end
  endtask

  // ********************
  // main sequence
  // ********************

  initial begin
    int errs_before;
    s_soc_rstn      = 1'b0;
    cl_evt_toggle_i = '0;
    cl_evt_ack_i    = 1'b0;
    cur_delay       = 0;
    pending         = 1'b0;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    for (int s = 0; s < `N_CL_EVT_SRC; s++) begin
      model_seq[s] = '0;
    end
    load_rows();
    cycle_limit = stall_limit();
    repeat (4) @(negedge s_soc_clk);
    s_soc_rstn = 1'b1;

    @(negedge s_soc_clk);
    errs_before = errors;
    check_value("cl_evt_req_o", 8'h00, 8'(cl_evt_req_o));
    check_value("cl_evt_ack_o", 8'h00, 8'(cl_evt_ack_o));
    check_value("cl_evt_data_o", 8'h00, cl_evt_data_o);
    report_test("reset values", errs_before);

    for (int r = 0; r < N_ROWS; r++) begin
      errs_before = errors;
      cur_delay   = stim_rows[r].delay;
      for (int n = 0; n < stim_rows[r].reps; n++) begin
        raise_events(stim_rows[r].mask);
        compare_words();
      end
      report_test(row_names[r], errs_before);
    end

    // link must go quiet with nothing extra delivered
    repeat (10) @(negedge s_soc_clk);
    errs_before = errors;
    if (received_q.size() != 0) begin
      $display("%0d event words arrived after the last row", received_q.size());
      errors++;
    end
    check_value("cl_evt_req_o", 8'(cl_evt_ack_i), 8'(cl_evt_req_o));
    report_test("link idle at end", errs_before);

    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
